/* Makefile */
# Verilator build and run of the ooo core slice testbench

VERILATOR ?= verilator
TOP       ?= ooo_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/ooo_pkg.sv */
package ooo_pkg;

    // default rob size, must be a power of two
    parameter int ROB_DEPTH_DEF = 16;
    parameter int DATA_W        = 32;

    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_XOR = 4'h2,
        OP_MUL = 4'h3,
        OP_LI  = 4'h4
    } op_e;

    //////////////////////////////
    // instruction word formats
    //////////////////////////////

    // register-style ops, two 12-bit immediates
    typedef struct packed {
        op_e         op;
        logic [3:0]  rd;
        logic [11:0] src_a;
        logic [11:0] src_b;
    } alu_fmt_t;

    // load immediate, one wide field
    typedef struct packed {
        op_e         op;
        logic [3:0]  rd;
        logic [23:0] imm;
    } li_fmt_t;

    // op sits in the top nibble in both views
    typedef union packed {
        alu_fmt_t alu;
        li_fmt_t  li;
    } inst_word_u;

    //////////////////////////////
    // pipeline records
    //////////////////////////////

    typedef logic [3:0] rob_id_t;

    typedef struct packed {
        logic              valid;
        rob_id_t           rob_id;
        logic [3:0]        areg;
        logic              is_mul;
        op_e               op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } dispatch_t;

    // instruction table entry
    typedef struct packed {
        logic [3:0] areg;
    } rob_inst_t;

    typedef struct packed {
        logic              valid;
        rob_id_t           rob_id;
        logic [DATA_W-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic              valid;
        rob_id_t           rob_id;
        logic [3:0]        areg;
        logic [DATA_W-1:0] data;
    } commit_t;

endpackage

/* dv/ooo_asserts.sv */
module ooo_asserts #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input logic                       clk,
    input logic                       arst_n_i,
    input logic                       flush_i,
    input logic                       cm0_vld_i,
    input logic                       cm1_vld_i,
    input logic [$clog2(ROB_DEPTH):0] cnt_i
);

    // the younger slot only retires behind the older one
    a_slot_order: assert property (
        @(posedge clk) disable iff (!arst_n_i) cm1_vld_i |-> cm0_vld_i
    ) else $error("commit slot 1 valid without slot 0");

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!arst_n_i) cnt_i <= ROB_DEPTH
    ) else $error("rob count above depth");

    // flush empties the rob on its edge
    a_flush_quiet: assert property (
        @(posedge clk) disable iff (!arst_n_i) flush_i |=> !cm0_vld_i && !cm1_vld_i
    ) else $error("commit valid in the cycle after a flush");

endmodule

bind rob ooo_asserts #(
    .ROB_DEPTH(ROB_DEPTH)
) asserts_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .cm0_vld_i(commit_o[0].valid),
    .cm1_vld_i(commit_o[1].valid),
    .cnt_i    (cnt_q)
);

/* dv/ooo_tb.sv */
module ooo_tb;
    import ooo_pkg::*;

    localparam int ROB_DEPTH = ROB_DEPTH_DEF;
    localparam int N_TESTS   = 13;
    localparam int WATCH_CYC = N_TESTS * 200 + 8;

    logic       clk;
    logic       arst_n;
    logic       flush;
    inst_word_u inst [2];
    logic [1:0] inst_valid;
    logic       inst_ready;
    commit_t    commit [2];

    // test table where pair k uses words 2k and 2k+1
    string       t_name  [N_TESTS];
    logic [31:0] t_words [N_TESTS][8];
    logic [7:0]  t_valid [N_TESTS];
    bit          t_flush [N_TESTS];

    // reference model state
    commit_t     exp_q [$];
    int          acc_q [$];
    rob_id_t     next_id;
    logic        hold_m;
    int          cyc;
    logic [15:0] lfsr;
    string       cur_name;
    int          n_errors;
    int          n_checks;
    int          n_commits;

    ooo_top #(
        .ROB_DEPTH(ROB_DEPTH)
    ) dut_i (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .flush_i     (flush),
        .inst_i      (inst),
        .inst_valid_i(inst_valid),
        .inst_ready_o(inst_ready),
        .commit_o    (commit)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // word builders and model
    //////////////////////////////

    function automatic logic [31:0] alu_word(op_e op, logic [3:0] rd,
                                             logic [11:0] a, logic [11:0] b);
        return {op, rd, a, b};
    endfunction

    function automatic logic [31:0] li_word(logic [3:0] rd, logic [23:0] imm);
        return {OP_LI, rd, imm};
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return r;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [2:0]  pick;
        logic [3:0]  rd;
        logic [11:0] a;
        logic [11:0] b;
        pick = 3'(rand_bits(3) % 5);
        rd   = 4'(rand_bits(4));
        a    = 12'(rand_bits(12));
        b    = 12'(rand_bits(12));
        case (pick)
            3'd0:    return alu_word(OP_ADD, rd, a, b);
            3'd1:    return alu_word(OP_SUB, rd, a, b);
            3'd2:    return alu_word(OP_XOR, rd, a, b);
            3'd3:    return alu_word(OP_MUL, rd, a, b);
            default: return li_word(rd, {a, b});
        endcase
    endfunction

    // operands are zero-extended and results wrap at 32 bits
    function automatic logic [31:0] ref_result(logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        a = {20'h0, w[23:12]};
        b = {20'h0, w[11:0]};
        case (w[31:28])
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            default: return {8'h00, w[23:0]};
        endcase
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_commit(string name, commit_t exp, commit_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display(
                "ERROR %s: commit expected id %0d reg %0d data %h, actual id %0d reg %0d data %h",
                name, exp.rob_id, exp.areg, exp.data, act.rob_id, act.areg, act.data);
        end
    endtask

    task automatic check_ready(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: inst_ready expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("ERROR %s: commit latency expected %0d actual %0d", name, exp, act);
        end
    endtask

    // outputs settle by mid cycle so compare on the falling edge
    always @(negedge clk) begin : monitor
        commit_t     e;
        int          acc;
        logic [31:0] w;
        logic [1:0]  mul_s;
        if (arst_n) begin
            cyc++;
            check_ready(cur_name, !flush && !hold_m && (exp_q.size() <= ROB_DEPTH - 2),
                        inst_ready);
            if (commit[1].valid && !commit[0].valid) begin
                n_errors++;
                $display("%s: commit slot 1 valid while slot 0 is idle", cur_name);
            end
            for (int s = 0; s < 2; s++) begin
                if (commit[s].valid && exp_q.size() == 0) begin
                    n_errors++;
                    $display("%s: commit of rob id %0d with no word pending",
                             cur_name, commit[s].rob_id);
                end else if (commit[s].valid) begin
                    e   = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    check_commit(cur_name, e, commit[s]);
                    if (acc >= 0) begin
                        check_latency(cur_name, 2, cyc - acc);
                    end
                    n_commits++;
                end
            end
            mul_s  = '0;
            hold_m = 1'b0;
            if (flush) begin
                exp_q.delete();
                acc_q.delete();
                next_id = '0;
            end else if (inst_ready && |inst_valid) begin
                // slot 0 first and a lone slot 1 counts as the oldest
                for (int s = 0; s < 2; s++) begin
                    w        = inst[s];
                    mul_s[s] = (w[31:28] == OP_MUL);
                    if (inst_valid[s]) begin
                        e.valid  = 1'b1;
                        e.rob_id = next_id;
                        e.areg   = w[27:24];
                        e.data   = ref_result(w);
                        acc      = (exp_q.size() == 0 && !mul_s[s]) ? cyc : -1;
                        exp_q.push_back(e);
                        acc_q.push_back(acc);
                        next_id++;
                    end
                end
                hold_m = &inst_valid && (mul_s[0] == mul_s[1]);
            end
        end
    end

    //////////////////////////////
    // table and sequencing
    //////////////////////////////

    task automatic set_entry(int i, string name, logic [7:0] valid, bit fl);
        t_name[i]  = name;
        t_valid[i] = valid;
        t_flush[i] = fl;
    endtask

    task automatic build_table();
        set_entry(0, "alu_add_sub", 8'h12, 1'b0);
        t_words[0] = '{default: '0};
        t_words[0][1] = alu_word(OP_ADD, 4'd1, 12'h123, 12'h456);
        t_words[0][4] = alu_word(OP_SUB, 4'd2, 12'h010, 12'h020);
        set_entry(1, "alu_xor_li", 8'h11, 1'b0);
        t_words[1] = '{default: '0};
        t_words[1][0] = alu_word(OP_XOR, 4'd3, 12'hF0F, 12'h0FF);
        t_words[1][4] = li_word(4'd4, 24'hABCDEF);
        set_entry(2, "mul_then_alu", 8'h0F, 1'b0);
        t_words[2] = '{default: '0};
        t_words[2][0] = alu_word(OP_MUL, 4'd5, 12'hFFF, 12'hFFF);
        t_words[2][1] = alu_word(OP_ADD, 4'd6, 12'h7FF, 12'h001);
        t_words[2][2] = li_word(4'd7, 24'h123456);
        t_words[2][3] = alu_word(OP_MUL, 4'd8, 12'hABC, 12'h321);
        set_entry(3, "alu_pair_split", 8'h0F, 1'b0);
        t_words[3] = '{default: '0};
        t_words[3][0] = alu_word(OP_ADD, 4'd9, 12'h001, 12'h002);
        t_words[3][1] = alu_word(OP_XOR, 4'd10, 12'hAAA, 12'h555);
        t_words[3][2] = alu_word(OP_SUB, 4'd11, 12'h000, 12'h001);
        t_words[3][3] = li_word(4'd12, 24'h000FFF);
        set_entry(4, "mul_pair_split", 8'h0F, 1'b0);
        t_words[4] = '{default: '0};
        t_words[4][0] = alu_word(OP_MUL, 4'd13, 12'h012, 12'h034);
        t_words[4][1] = alu_word(OP_MUL, 4'd14, 12'hFFF, 12'h002);
        t_words[4][2] = alu_word(OP_MUL, 4'd15, 12'h800, 12'h800);
        t_words[4][3] = alu_word(OP_MUL, 4'd0, 12'h003, 12'h005);
        // flush lands while the last muls are still in the pipe
        set_entry(5, "flush_muls", 8'hFF, 1'b1);
        for (int j = 0; j < 4; j++) begin
            t_words[5][2*j]   = alu_word(OP_MUL, 4'(2*j), 12'(j + 3), 12'h111);
            t_words[5][2*j+1] = alu_word(OP_ADD, 4'(2*j+1), 12'(j), 12'h001);
        end
        set_entry(6, "after_flush", 8'h13, 1'b0);
        t_words[6] = '{default: '0};
        t_words[6][0] = alu_word(OP_ADD, 4'd9, 12'h00A, 12'h005);
        t_words[6][1] = li_word(4'd10, 24'h00BEEF);
        t_words[6][4] = alu_word(OP_XOR, 4'd11, 12'hF00, 12'h0F0);
        for (int i = 7; i < N_TESTS; i++) begin
            set_entry(i, $sformatf("random_%0d", i - 7), 8'(rand_bits(8)), i == 10);
            if (t_valid[i] == 8'h00) begin
                t_valid[i] = 8'hFF;
            end
            for (int j = 0; j < 8; j++) begin
                t_words[i][j] = rand_word();
            end
        end
    endtask

    task automatic run_test(int i);
        int   err0;
        int   wait_cyc;
        logic acc;
        err0      = n_errors;
        cur_name  = t_name[i];
        n_commits = 0;
        for (int k = 0; k < 4; k++) begin
            inst[0]    = t_words[i][2*k];
            inst[1]    = t_words[i][2*k+1];
            inst_valid = t_valid[i][2*k +: 2];
            acc        = (inst_valid == 2'b00);
            // keep the pair on the inputs until it is taken
            do begin
                @(negedge clk);
                acc = acc || inst_ready;
                @(posedge clk);
                #10;
            end while (!acc);
        end
        inst_valid = '0;
        if (t_flush[i]) begin
            flush = 1'b1;
            @(posedge clk);
            #10;
            flush = 1'b0;
        end
        wait_cyc = 0;
        while (exp_q.size() != 0 && wait_cyc < 200) begin
            @(posedge clk);
            wait_cyc++;
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("%s: %0d accepted words never committed", cur_name, exp_q.size());
        end
        // idle gap shows up any stray commit
        repeat (4) @(posedge clk);
        #10;
        $display("test %-14s %0d commits, %0d errors", cur_name, n_commits, n_errors - err0);
    endtask

    initial begin : watchdog
        repeat (WATCH_CYC) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCH_CYC);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        clk        = 1'b0;
        arst_n     = 1'b0;
        flush      = 1'b0;
        inst[0]    = '0;
        inst[1]    = '0;
        inst_valid = '0;
        lfsr       = 16'd23879;
        next_id    = '0;
        hold_m     = 1'b0;
        cyc        = 0;
        n_errors   = 0;
        n_checks   = 0;
        n_commits  = 0;
        cur_name   = "reset";
        build_table();
        repeat (4) @(posedge clk);
        #10;
        arst_n = 1'b1;
        for (int i = 0; i < N_TESTS; i++) begin
            run_test(i);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", N_TESTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* hw/exec_unit.sv */
module exec_unit (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               flush_i,
    input  ooo_pkg::dispatch_t disp_i [2],
    output ooo_pkg::cdb_t      cdb_o [2]
);
    import ooo_pkg::*;

    //////////////////////////////
    // alu lane, one cycle
    //////////////////////////////

    logic [DATA_W-1:0] alu_res;
    logic              alu_vld_q;
    rob_id_t           alu_id_q;
    logic [DATA_W-1:0] alu_data_q;

    always_comb begin
        case (disp_i[0].op)
            OP_ADD:  alu_res = disp_i[0].a + disp_i[0].b;
            OP_SUB:  alu_res = disp_i[0].a - disp_i[0].b;
            OP_XOR:  alu_res = disp_i[0].a ^ disp_i[0].b;
            // li passes the immediate through
            default: alu_res = disp_i[0].a;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_vld_q <= 1'b0;
        end else begin
            alu_vld_q <= disp_i[0].valid && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_id_q   <= disp_i[0].rob_id;
        alu_data_q <= alu_res;
    end

    //////////////////////////////
    // mul lane, three stages
    //////////////////////////////

    logic [2:0]        mul_vld_q;
    rob_id_t           mul_id_q [3];
    logic [DATA_W-1:0] m1_a_q;
    logic [DATA_W-1:0] m1_b_q;
    logic [DATA_W-1:0] pp_lo_q;
    logic [15:0]       pp_hi_q;
    logic [DATA_W-1:0] prod_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mul_vld_q <= '0;
        end else if (flush_i) begin
            mul_vld_q <= '0;
        end else begin
            mul_vld_q <= {mul_vld_q[1:0], disp_i[1].valid};
        end
    end

    // low word only: a_hi * b_hi falls off the top
    always_ff @(posedge clk) begin
        m1_a_q      <= disp_i[1].a;
        m1_b_q      <= disp_i[1].b;
        mul_id_q[0] <= disp_i[1].rob_id;
        pp_lo_q     <= DATA_W'(m1_a_q[15:0] * m1_b_q);
        pp_hi_q     <= 16'(m1_a_q[31:16] * m1_b_q[15:0]);
        mul_id_q[1] <= mul_id_q[0];
        prod_q      <= pp_lo_q + {pp_hi_q, 16'h0000};
        mul_id_q[2] <= mul_id_q[1];
    end

    always_comb begin
        cdb_o[0].valid  = alu_vld_q;
        cdb_o[0].rob_id = alu_id_q;
        cdb_o[0].data   = alu_data_q;
        cdb_o[1].valid  = mul_vld_q[2];
        cdb_o[1].rob_id = mul_id_q[2];
        cdb_o[1].data   = prod_q;
    end

endmodule

/* hw/inst_decoder.sv */
module inst_decoder #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  ooo_pkg::inst_word_u  inst_i [2],
    input  logic [1:0]           inst_valid_i,
    input  logic                 free_ok_i,
    output logic                 inst_ready_o,
    output ooo_pkg::dispatch_t   disp_o [2]
);
    import ooo_pkg::*;

    localparam int ID_W = $clog2(ROB_DEPTH);
    typedef logic [ID_W-1:0] id_t;

    id_t        head_q;
    logic       hold_vld_q;
    inst_word_u hold_word_q;
    inst_word_u word0;
    logic       v0;
    logic       v1;
    logic       accept;
    logic       hold_set;
    logic [1:0] n_sent;
    dispatch_t  d0;
    dispatch_t  d1;

    function automatic dispatch_t build_disp(inst_word_u w, id_t id);
        dispatch_t d;
        d        = '0;
        d.valid  = 1'b1;
        d.rob_id = rob_id_t'(id);
        d.op     = w.alu.op;
        d.areg   = w.alu.rd;
        d.is_mul = (w.alu.op == OP_MUL);
        if (w.li.op == OP_LI) begin
            d.a    = DATA_W'(w.li.imm);
            d.b    = '0;
        end else begin
            d.a    = DATA_W'(w.alu.src_a);
            d.b    = DATA_W'(w.alu.src_b);
        end
        return d;
    endfunction

    // a lone slot 1 moves down to slot 0
    assign word0 = inst_valid_i[0] ? inst_i[0] : inst_i[1];
    assign v0    = |inst_valid_i;
    assign v1    = &inst_valid_i;

    assign inst_ready_o = !hold_vld_q && free_ok_i && !flush_i;
    assign accept       = inst_ready_o && v0;

    always_comb begin
        disp_o[0] = '0;
        disp_o[1] = '0;
        hold_set  = 1'b0;
        n_sent    = 2'd0;
        d0        = build_disp(hold_vld_q ? hold_word_q : word0, head_q);
        d1        = build_disp(inst_i[1], head_q + 1'b1);
        if (hold_vld_q && !flush_i) begin
            // younger half of a split pair
            disp_o[d0.is_mul] = d0;
            n_sent            = 2'd1;
        end else if (accept) begin
            disp_o[d0.is_mul] = d0;
            n_sent            = 2'd1;
            if (v1) begin
                if (d1.is_mul == d0.is_mul) begin
                    hold_set = 1'b1;
                end else begin
                    disp_o[d1.is_mul] = d1;
                    n_sent            = 2'd2;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q     <= '0;
            hold_vld_q <= 1'b0;
        end else if (flush_i) begin
            head_q     <= '0;
            hold_vld_q <= 1'b0;
        end else begin
            head_q     <= head_q + id_t'(n_sent);
            hold_vld_q <= hold_set;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_set) begin
            hold_word_q <= inst_i[1];
        end
    end

endmodule

/* hw/ooo_top.sv */
module ooo_top #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                flush_i,
    input  ooo_pkg::inst_word_u inst_i [2],
    input  logic [1:0]          inst_valid_i,
    output logic                inst_ready_o,
    output ooo_pkg::commit_t    commit_o [2]
);
    import ooo_pkg::*;

    // lane 0 alu, lane 1 mul
    dispatch_t disp [2];
    cdb_t      cdb [2];
    logic      free_ok;

    inst_decoder #(
        .ROB_DEPTH(ROB_DEPTH)
    ) decoder_i (
        .clk,
        .arst_n_i,
        .flush_i,
        .inst_i,
        .inst_valid_i,
        .free_ok_i(free_ok),
        .inst_ready_o,
        .disp_o(disp)
    );

    exec_unit exec_i (
        .clk,
        .arst_n_i,
        .flush_i,
        .disp_i(disp),
        .cdb_o(cdb)
    );

    rob #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rob_i (
        .clk,
        .arst_n_i,
        .flush_i,
        .disp_i(disp),
        .cdb_i(cdb),
        .free_ok_o(free_ok),
        .commit_o
    );

endmodule

/* rob/rob.sv */
module rob #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               flush_i,
    input  ooo_pkg::dispatch_t disp_i [2],
    input  ooo_pkg::cdb_t      cdb_i [2],
    output logic               free_ok_o,
    output ooo_pkg::commit_t   commit_o [2]
);
    import ooo_pkg::*;

    localparam int ID_W = $clog2(ROB_DEPTH);
    localparam int CW   = ID_W + 1;
    typedef logic [ID_W-1:0] id_t;

    // tail is the oldest entry
    id_t                    tail_q;
    logic [CW-1:0]          cnt_q;
    id_t [1:0]              tail_addr;
    id_t [1:0]              disp_addr;
    id_t [1:0]              cdb_addr;
    logic [1:0]             disp_we;
    logic [1:0]             cdb_we;
    rob_inst_t [1:0]        disp_inst;
    rob_inst_t [1:0]        head_inst;
    logic [1:0][DATA_W-1:0] cdb_data;
    logic [1:0][DATA_W-1:0] head_data;
    logic [1:0]             disp_tog_head;
    logic [1:0]             cdb_tog_head;
    logic [1:0]             cdb_tog_disp;
    logic [1:0]             cdb_tog_self;
    logic [1:0]             done;
    logic [1:0]             cm_vld;
    logic [1:0]             n_disp;
    logic [1:0]             n_commit;

    always_comb begin
        tail_addr[0] = tail_q;
        tail_addr[1] = tail_q + 1'b1;
        for (int i = 0; i < 2; i++) begin
            disp_addr[i]      = id_t'(disp_i[i].rob_id);
            disp_we[i]        = disp_i[i].valid;
            disp_inst[i].areg = disp_i[i].areg;
            cdb_addr[i]       = id_t'(cdb_i[i].rob_id);
            cdb_we[i]         = cdb_i[i].valid;
            cdb_data[i]       = cdb_i[i].data;
        end
    end

    //////////////////////////////
    // tables
    //////////////////////////////

    rob_table #(
        .WIDTH($bits(rob_inst_t)), .DEPTH(ROB_DEPTH),
        .R_PORTS(2), .W_PORTS(2), .NEED_RESET(1'b0)
    ) inst_table (
        .clk, .arst_n_i, .clr_i(flush_i),
        .raddr_i(tail_addr), .rdata_o(head_inst),
        .waddr_i(disp_addr), .we_i(disp_we), .wdata_i(disp_inst)
    );

    rob_table #(
        .WIDTH(DATA_W), .DEPTH(ROB_DEPTH),
        .R_PORTS(2), .W_PORTS(2), .NEED_RESET(1'b0)
    ) data_table (
        .clk, .arst_n_i, .clr_i(flush_i),
        .raddr_i(tail_addr), .rdata_o(head_data),
        .waddr_i(cdb_addr), .we_i(cdb_we), .wdata_i(cdb_data)
    );

    // dispatch copies the cdb bit, so the pair reads as pending
    rob_table #(
        .WIDTH(1), .DEPTH(ROB_DEPTH),
        .R_PORTS(2), .W_PORTS(2), .NEED_RESET(1'b1)
    ) disp_tog_table (
        .clk, .arst_n_i, .clr_i(flush_i),
        .raddr_i(tail_addr), .rdata_o(disp_tog_head),
        .waddr_i(disp_addr), .we_i(disp_we), .wdata_i(cdb_tog_disp)
    );

    // a result flips its own bit
    rob_table #(
        .WIDTH(1), .DEPTH(ROB_DEPTH),
        .R_PORTS(6), .W_PORTS(2), .NEED_RESET(1'b1)
    ) cdb_tog_table (
        .clk, .arst_n_i, .clr_i(flush_i),
        .raddr_i({cdb_addr, disp_addr, tail_addr}),
        .rdata_o({cdb_tog_self, cdb_tog_disp, cdb_tog_head}),
        .waddr_i(cdb_addr), .we_i(cdb_we), .wdata_i(~cdb_tog_self)
    );

    //////////////////////////////
    // in-order commit
    //////////////////////////////

    assign done      = disp_tog_head ^ cdb_tog_head;
    assign cm_vld[0] = (cnt_q != '0) && done[0];
    assign cm_vld[1] = cm_vld[0] && (cnt_q > CW'(1)) && done[1];
    assign n_disp    = {1'b0, disp_we[0]} + {1'b0, disp_we[1]};
    assign n_commit  = {1'b0, cm_vld[0]} + {1'b0, cm_vld[1]};
    assign free_ok_o = (cnt_q <= CW'(ROB_DEPTH - 2));

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit_o[i].valid  = cm_vld[i];
            commit_o[i].rob_id = rob_id_t'(tail_addr[i]);
            commit_o[i].areg   = head_inst[i].areg;
            commit_o[i].data   = head_data[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tail_q <= '0;
            cnt_q  <= '0;
        end else if (flush_i) begin
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            tail_q <= tail_q + id_t'(n_commit);
            cnt_q  <= cnt_q + CW'(n_disp) - CW'(n_commit);
        end
    end

endmodule

/* rob/rob_table.sv */
module rob_table #(
    parameter int WIDTH      = 1,
    parameter int DEPTH      = 16,
    parameter int R_PORTS    = 2,
    parameter int W_PORTS    = 2,
    parameter bit NEED_RESET = 1'b0,
    localparam int AW        = $clog2(DEPTH)
) (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  logic                              clr_i,
    input  logic [R_PORTS-1:0][AW-1:0]        raddr_i,
    output logic [R_PORTS-1:0][WIDTH-1:0]     rdata_o,
    input  logic [W_PORTS-1:0][AW-1:0]        waddr_i,
    input  logic [W_PORTS-1:0]                we_i,
    input  logic [W_PORTS-1:0][WIDTH-1:0]     wdata_i
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    // combinational read ports
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem_q[raddr_i[r]];
        end
    end

    // later ports overwrite earlier ones on the same address
    if (NEED_RESET) begin : g_rst
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                mem_q <= '{default: '0};
            end else if (clr_i) begin
                mem_q <= '{default: '0};
            end else begin
                for (int w = 0; w < W_PORTS; w++) begin
                    if (we_i[w]) mem_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end else begin : g_plain
        always_ff @(posedge clk) begin
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) mem_q[waddr_i[w]] <= wdata_i[w];
            end
        end
    end

endmodule

/* src.f */
common/ooo_pkg.sv
rob/rob_table.sv
rob/rob.sv
hw/inst_decoder.sv
hw/exec_unit.sv
hw/ooo_top.sv
dv/ooo_asserts.sv
dv/ooo_tb.sv
